/* Makefile */
# Verilator build and run of the LSU testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
SEED_ARGS ?=
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* rtl/lsu_bus_ctrl.sv */
// assumes rvalid comes at least one cycle after its grant and only for accepted requests
`default_nettype none
`include "lsu_config.svh"

module lsu_bus_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic data_req_ex_i,   // EX wants an access
  input  wire logic data_gnt_i,
  input  wire logic data_rvalid_i,
  output logic      data_req_o,
  output logic      ctrl_update_o,   // access leaves EX and enters WB
  output logic      lsu_ready_ex_o,
  output logic      lsu_ready_wb_o,
  output logic      busy_o
);

  localparam logic [`LSU_CNT_W-1:0] MaxOutst = `LSU_CNT_W'(`LSU_MAX_OUTST);

  logic [`LSU_CNT_W-1:0] cnt_q;     // outstanding transactions
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  count_up;  // request accepted this cycle
  logic                  count_down; // response returned this cycle

  //////////////////////////////
  // request issue
  //////////////////////////////

  // no path from rvalid to req, only the count gates issue
  assign data_req_o = data_req_ex_i && (cnt_q < MaxOutst);

  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  //////////////////////////////
  // pipeline handshake
  //////////////////////////////

  // WB is free when empty, or when its pending response arrives
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // EX and WB advance in lock step once WB holds an access
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;                       // nothing to issue
    end else if (cnt_q == '0) begin
      lsu_ready_ex_o = count_up;                   // grant alone moves it on
    end else if (cnt_q == `LSU_CNT_W'(1)) begin
      lsu_ready_ex_o = count_up && data_rvalid_i;  // need grant and WB slot
    end else begin
      lsu_ready_ex_o = data_rvalid_i;              // full, req is held off
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;

  // anything in flight or being offered
  assign busy_o = (cnt_q != '0) || data_req_o;

  //////////////////////////////
  // outstanding counter
  //////////////////////////////

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;       // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/lsu_config.svh */
// only 32-bit data with 4 byte lanes is supported, and outstanding depth must stay at 3 or less
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

`define LSU_XLEN 32       // data and address width
`define LSU_BE_W 4        // one enable per byte lane

//////////////////////////////
// bus depth
//////////////////////////////

// max transactions in flight between grant and rvalid
`define LSU_MAX_OUTST 2

// counter must hold LSU_MAX_OUTST without wrapping
`define LSU_CNT_W 2

`endif

/* rtl/lsu_load_align.sv */
// load responses must come back in order; split loads rely on the first word staying in rdata_q
`default_nettype none
`include "lsu_config.svh"

module lsu_load_align (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 ctrl_update_i,   // capture EX control into WB
  input  wire lsu_pkg::data_type_e  data_type_i,
  input  wire lsu_pkg::sign_ext_e   sign_ext_i,
  input  wire logic                 we_i,
  input  wire logic [1:0]           offset_i,        // low address bits of the access
  input  wire logic                 rvalid_i,
  input  wire logic [`LSU_XLEN-1:0] rdata_i,
  input  wire logic                 misaligned_ex_i, // EX is in the second phase
  input  wire logic                 misaligned_i,    // EX first phase will split
  output logic [`LSU_XLEN-1:0]      rdata_ex_o
);
  import lsu_pkg::*;

  // WB control copy
  data_type_e            data_type_q;
  sign_ext_e             sign_ext_q;
  logic                  we_q;
  logic [1:0]            offset_q;

  logic [`LSU_XLEN-1:0]  rdata_q;   // first word of a split, or last result
  logic [`LSU_XLEN-1:0]  word_ext;  // assembled word
  logic [15:0]           half_raw;
  logic [7:0]            byte_raw;
  logic [`LSU_XLEN-1:0]  half_ext;
  logic [`LSU_XLEN-1:0]  byte_ext;
  logic [`LSU_XLEN-1:0]  result;

  // upper fill bit for a given extension mode
  function automatic logic fill_bit(input sign_ext_e mode, input logic msb);
    case (mode)
      SX_ZERO: fill_bit = 1'b0;
      SX_ONES: fill_bit = 1'b1;
      default: fill_bit = msb;      // SX_SIGN and code 3
    endcase
  endfunction

  //////////////////////////////
  // WB control registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_type_q <= DT_WORD;
      sign_ext_q  <= SX_ZERO;
      we_q        <= 1'b0;
      offset_q    <= 2'b00;
    end else if (ctrl_update_i) begin   // access granted, moves to WB
      data_type_q <= data_type_i;
      sign_ext_q  <= sign_ext_i;
      we_q        <= we_i;
      offset_q    <= offset_i;
    end
  end

  //////////////////////////////
  // alignment and extension
  //////////////////////////////

  // low bytes of the new word sit above the tail of the stored one
  always_comb begin
    case (offset_q)
      2'b00: word_ext = rdata_i;
      2'b01: word_ext = {rdata_i[7:0],  rdata_q[31:8]};
      2'b10: word_ext = {rdata_i[15:0], rdata_q[31:16]};
      2'b11: word_ext = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (offset_q)
      2'b00: half_raw = rdata_i[15:0];
      2'b01: half_raw = rdata_i[23:8];
      2'b10: half_raw = rdata_i[31:16];
      2'b11: half_raw = {rdata_i[7:0], rdata_q[31:24]};  // split half
    endcase
  end

  assign byte_raw = rdata_i[8*offset_q +: 8];  // bytes never split

  assign half_ext = {{16{fill_bit(sign_ext_q, half_raw[15])}}, half_raw};
  assign byte_ext = {{24{fill_bit(sign_ext_q, byte_raw[7])}}, byte_raw};

  always_comb begin
    case (data_type_q)
      DT_WORD: result = word_ext;
      DT_HALF: result = half_ext;
      default: result = byte_ext;   // DT_BYTE and code 3
    endcase
  end

  //////////////////////////////
  // load data register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rvalid_i && !we_q) begin
      if (misaligned_ex_i || misaligned_i) begin
        rdata_q <= rdata_i;         // keep raw word for the second phase
      end else begin
        rdata_q <= result;
      end
    end
  end

  // live on the response cycle, held afterwards
  assign rdata_ex_o = rvalid_i ? result : rdata_q;

endmodule

`default_nettype wire

/* rtl/lsu_pkg.sv */
// access sizes and load extension modes; encodings match the core decode, codes 3 alias as noted
`default_nettype none

package lsu_pkg;

  //////////////////////////////
  // access size
  //////////////////////////////

  // code 3 is decoded like a byte
  typedef enum logic [1:0] {
    DT_WORD = 2'd0,           // 32 bit
    DT_HALF = 2'd1,           // 16 bit
    DT_BYTE = 2'd2            // 8 bit
  } data_type_e;

  //////////////////////////////
  // load extension
  //////////////////////////////

  // code 3 behaves like SX_SIGN
  typedef enum logic [1:0] {
    SX_ZERO = 2'd0,           // fill upper bits with 0
    SX_SIGN = 2'd1,           // replicate msb of loaded value
    SX_ONES = 2'd2            // fill upper bits with 1
  } sign_ext_e;

endpackage

`default_nettype wire

/* rtl/lsu_store_align.sv */
// combinational only; data_misaligned_i must be high for the whole second phase of a split access
`default_nettype none
`include "lsu_config.svh"

module lsu_store_align (
  input  wire logic [`LSU_XLEN-1:0] operand_a_i,
  input  wire logic [`LSU_XLEN-1:0] operand_b_i,
  input  wire logic                 addr_useincr_i,   // a+b when set, else a alone
  input  wire lsu_pkg::data_type_e  data_type_i,
  input  wire logic [`LSU_XLEN-1:0] data_wdata_i,
  input  wire logic [1:0]           data_reg_offset_i, // byte offset of data in the register
  input  wire logic                 data_req_i,
  input  wire logic                 data_misaligned_i, // second phase of split access
  output logic [`LSU_XLEN-1:0]      addr_o,            // raw effective address
  output logic [`LSU_XLEN-1:0]      trans_addr_o,      // address put on the bus
  output logic [`LSU_BE_W-1:0]      be_o,
  output logic [`LSU_XLEN-1:0]      wdata_o,
  output logic                      misaligned_o       // first phase needs a second access
);
  import lsu_pkg::*;

  logic [1:0] wdata_offset;   // lane rotation amount

  //////////////////////////////
  // address
  //////////////////////////////

  assign addr_o = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;

  // second phase always starts at lane 0 of the next word
  assign trans_addr_o = data_misaligned_i ? {addr_o[`LSU_XLEN-1:2], 2'b00} : addr_o;

  //////////////////////////////
  // misalignment detect
  //////////////////////////////

  always_comb begin
    misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_i) begin   // only flagged in the first phase
      case (data_type_i)
        DT_WORD: misaligned_o = (addr_o[1:0] != 2'b00);
        DT_HALF: misaligned_o = (addr_o[1:0] == 2'b11);  // half crosses into next word
        default: misaligned_o = 1'b0;                    // bytes never split
      endcase
    end
  end

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    case (data_type_i)
      DT_WORD: begin
        if (!data_misaligned_i) begin
          case (addr_o[1:0])
            2'b00: be_o = 4'b1111;
            2'b01: be_o = 4'b1110;
            2'b10: be_o = 4'b1100;
            2'b11: be_o = 4'b1000;
          endcase
        end else begin                  // remaining low lanes of the next word
          case (addr_o[1:0])
            2'b00: be_o = 4'b0000;      // aligned word has no second phase
            2'b01: be_o = 4'b0001;
            2'b10: be_o = 4'b0011;
            2'b11: be_o = 4'b0111;
          endcase
        end
      end
      DT_HALF: begin
        if (!data_misaligned_i) begin
          case (addr_o[1:0])
            2'b00: be_o = 4'b0011;
            2'b01: be_o = 4'b0110;
            2'b10: be_o = 4'b1100;
            2'b11: be_o = 4'b1000;      // upper byte goes out in phase two
          endcase
        end else begin
          be_o = 4'b0001;
        end
      end
      default: be_o = 4'b0001 << addr_o[1:0];  // byte, one lane
    endcase
  end

  //////////////////////////////
  // store data rotation
  //////////////////////////////

  // rotate left by the lane difference, wraps mod 4
  assign wdata_offset = addr_o[1:0] - data_reg_offset_i;

  always_comb begin
    case (wdata_offset)
      2'b00: wdata_o = data_wdata_i;
      2'b01: wdata_o = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'b10: wdata_o = {data_wdata_i[15:0], data_wdata_i[31:16]};
      2'b11: wdata_o = {data_wdata_i[7:0],  data_wdata_i[31:8]};
    endcase
  end

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
// core holds EX inputs until lsu_ready_ex_o; bus must answer each grant once, in order
`default_nettype none
`include "lsu_config.svh"

module lsu_top (
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // data bus
  output logic                      data_req_o,
  input  wire logic                 data_gnt_i,
  input  wire logic                 data_rvalid_i,
  output logic [`LSU_XLEN-1:0]      data_addr_o,
  output logic                      data_we_o,
  output logic [`LSU_BE_W-1:0]      data_be_o,
  output logic [`LSU_XLEN-1:0]      data_wdata_o,
  input  wire logic [`LSU_XLEN-1:0] data_rdata_i,

  // EX stage
  input  wire logic                 data_req_ex_i,
  input  wire logic                 data_we_ex_i,
  input  wire logic [1:0]           data_type_ex_i,      // lsu_pkg::data_type_e code
  input  wire logic [1:0]           data_sign_ext_ex_i,  // lsu_pkg::sign_ext_e code
  input  wire logic [`LSU_XLEN-1:0] data_wdata_ex_i,
  input  wire logic [1:0]           data_reg_offset_ex_i,
  input  wire logic [`LSU_XLEN-1:0] operand_a_ex_i,
  input  wire logic [`LSU_XLEN-1:0] operand_b_ex_i,
  input  wire logic                 addr_useincr_ex_i,
  input  wire logic                 data_misaligned_ex_i,
  output logic                      data_misaligned_o,
  output logic [`LSU_XLEN-1:0]      data_rdata_ex_o,

  // pipeline control
  output logic                      lsu_ready_ex_o,
  output logic                      lsu_ready_wb_o,
  output logic                      busy_o
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] addr_raw;     // effective address before phase-two alignment
  logic                 ctrl_update;  // EX to WB handoff

  assign data_we_o = data_we_ex_i;    // write flag goes straight to the bus

  //////////////////////////////
  // request side
  //////////////////////////////

  lsu_store_align u_store_align (
    .operand_a_i       (operand_a_ex_i),
    .operand_b_i       (operand_b_ex_i),
    .addr_useincr_i    (addr_useincr_ex_i),
    .data_type_i       (data_type_e'(data_type_ex_i)),
    .data_wdata_i      (data_wdata_ex_i),
    .data_reg_offset_i (data_reg_offset_ex_i),
    .data_req_i        (data_req_ex_i),
    .data_misaligned_i (data_misaligned_ex_i),
    .addr_o            (addr_raw),
    .trans_addr_o      (data_addr_o),
    .be_o              (data_be_o),
    .wdata_o           (data_wdata_o),
    .misaligned_o      (data_misaligned_o)
  );

  lsu_bus_ctrl u_bus_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .ctrl_update_o  (ctrl_update),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  //////////////////////////////
  // response side
  //////////////////////////////

  lsu_load_align u_load_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_update_i   (ctrl_update),
    .data_type_i     (data_type_e'(data_type_ex_i)),
    .sign_ext_i      (sign_ext_e'(data_sign_ext_ex_i)),
    .we_i            (data_we_ex_i),
    .offset_i        (addr_raw[1:0]),      // lane of the raw address, kept for both phases
    .rvalid_i        (data_rvalid_i),
    .rdata_i         (data_rdata_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .misaligned_i    (data_misaligned_o),
    .rdata_ex_o      (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_store_align.sv
rtl/lsu_bus_ctrl.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
tests/lsu_mem_model.sv
tests/tb_lsu.sv

/* tests/lsu_mem_model.sv */
// word memory of 64 entries, only addr bits 7:2 decode; grants after 0..2 cycles, answers in order
`default_nettype none

module lsu_mem_model #(
  parameter int SEED = 70726
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        req_i,
  input  wire logic        we_i,
  input  wire logic [3:0]  be_i,
  input  wire logic [31:0] addr_i,
  input  wire logic [31:0] wdata_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output logic [31:0]      rdata_o,
  output logic [2:0]       outst_o     // granted, no rvalid issued yet
);

  logic [31:0] mem [0:63];
  logic [1:0]  gnt_wait;                // cycles left before the next grant
  logic [31:0] rsp_data [$];            // pending responses, oldest first
  int          rsp_due [$];
  int          cyc;
  int          last_due;                // keeps responses one per cycle and in order
  int          seed;

  // fill word mixes every address bit
  function automatic logic [31:0] fill_word(input int a);
    logic [31:0] w;
    w = 32'(a);
    fill_word = (w * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  initial begin
    seed = SEED;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
    end
  end

  assign gnt_o = req_i && (gnt_wait == 2'd0);   // zero delay grants in the request cycle

  //////////////////////////////
  // accept and respond
  //////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    int idx;
    int r;
    int due;
    if (!rst_n) begin
      gnt_wait <= 2'd0;
      rvalid_o <= 1'b0;
      rdata_o  <= 32'd0;
      outst_o  <= 3'd0;
      cyc      = 0;
      last_due = 0;
      rsp_data.delete();
      rsp_due.delete();
    end else begin
      cyc = cyc + 1;
      if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin   // head is due
        rvalid_o <= 1'b1;
        rdata_o  <= rsp_data.pop_front();
        void'(rsp_due.pop_front());
      end else begin
        rvalid_o <= 1'b0;
      end
      if (gnt_o) begin
        idx = int'(addr_i[7:2]);
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) mem[idx][8*b +: 8] = wdata_i[8*b +: 8];   // byte lanes
          end
        end
        r   = $random(seed);
        due = cyc + 1 + int'((r & 32'h7fff_ffff) % 3);   // 1..3 cycles later
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        rsp_data.push_back(mem[idx]);
        rsp_due.push_back(due);
        r = $random(seed);
        gnt_wait <= 2'((r & 32'h7fff_ffff) % 3);   // delay for the next request
      end else if (req_i && gnt_wait != 2'd0) begin
        gnt_wait <= gnt_wait - 2'd1;
      end
      outst_o <= 3'(rsp_due.size());
    end
  end

endmodule

`default_nettype wire

/* tests/tb_lsu.sv */
// drives one access at a time in one or two phases within the first 64 words of memory
`default_nettype none
`include "lsu_config.svh"

module tb_lsu;

  localparam int NUM_ACCESS = 300;
  localparam int CYCLE_LIMIT = NUM_ACCESS * 20;   // worst access stays well under 20 cycles

  logic        clk;
  logic        rst_n;
  logic        data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i, data_rdata_ex_o;
  logic [3:0]  data_be_o;
  logic        data_req_ex_i, data_we_ex_i, addr_useincr_ex_i, data_misaligned_ex_i;
  logic [1:0]  data_type_ex_i, data_sign_ext_ex_i, data_reg_offset_ex_i;
  logic [31:0] data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  logic        data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;
  logic [2:0]  mem_outst;

  int          seed;
  int          cycles;
  int          resp_seen;            // rvalids counted by the driver
  logic [31:0] last_rdata;           // load result on the latest rvalid
  logic [3:0]  exp_be;               // expected enables of the current phase
  logic [31:0] exp_lanes;            // expected bytes on enabled lanes
  logic        exp_mis;
  logic [7:0]  shadow [0:255];

  lsu_top dut0 (.*);

  lsu_mem_model #(.SEED(70726)) mem0 (
    .clk(clk), .rst_n(rst_n), .req_i(data_req_o), .we_i(data_we_o), .be_i(data_be_o),
    .addr_i(data_addr_o), .wdata_i(data_wdata_o), .gnt_o(data_gnt_i),
    .rvalid_o(data_rvalid_i), .rdata_o(data_rdata_i), .outst_o(mem_outst)
  );

  always #50 clk = ~clk;   // period 100

  task automatic report_error(input string msg);
    $display("[FAIL] t=%0t %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "stopping on first error");
  endtask

  function automatic int rand_below(input int lim);
    int r;
    r = $random(seed);
    rand_below = int'((r & 32'h7fff_ffff) % lim);
  endfunction

  // data byte k lands on lane k+off
  // phase two sees lanes 4..7 of that span
  function automatic logic [31:0] lanes_for(input logic [31:0] wd, input int off, input int n,
                                            input bit ph2);
    int k;
    lanes_for = 32'd0;
    for (int l = 0; l < 4; l++) begin
      k = ph2 ? (l + 4 - off) : (l - off);
      if (k >= 0 && k < n) lanes_for[8*l +: 8] = wd[8*k +: 8];
    end
  endfunction

  //////////////////////////////
  // bus watchers
  //////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  logic        held_q;               // last cycle offered a request without grant
  logic [31:0] held_addr, held_wdata;
  logic [3:0]  held_be;
  logic        held_we;

  always @(posedge clk) begin
    if (rst_n) begin
      if (held_q) begin
        assert (data_req_o && data_addr_o == held_addr && data_wdata_o == held_wdata &&
                data_be_o == held_be && data_we_o == held_we)
          else report_error("request fields changed before grant");
      end
      assert (mem_outst <= 3'd2) else report_error("more than two outstanding transactions");
      assert (!(data_rvalid_i && !busy_o)) else report_error("rvalid seen while busy_o low");
    end
    held_q     <= rst_n && data_req_o && !data_gnt_i;
    held_addr  <= data_addr_o;
    held_wdata <= data_wdata_o;
    held_be    <= data_be_o;
    held_we    <= data_we_o;
  end

  // in flight = model backlog plus the response on the bus this cycle
  always @(posedge clk) begin
    int   in_flight;
    logic exp_rdy;
    in_flight = int'(mem_outst) + int'(data_rvalid_i);
    if (!data_req_ex_i) begin
      exp_rdy = 1'b1;
    end else if (in_flight == 0) begin
      exp_rdy = data_gnt_i;
    end else if (in_flight == 1) begin
      exp_rdy = data_gnt_i && data_rvalid_i;
    end else begin
      exp_rdy = data_rvalid_i;
    end
    if (rst_n) begin
      assert (lsu_ready_wb_o == (in_flight == 0 || data_rvalid_i))
        else report_error("lsu_ready_wb_o wrong");
      assert (lsu_ready_ex_o == exp_rdy) else report_error("lsu_ready_ex_o wrong");
    end
  end

  //////////////////////////////
  // driver
  //////////////////////////////

  // one clock of checks on granted stores and the split flag, plus response capture
  task automatic tick();
    logic [31:0] m;
    @(posedge clk);
    m = 32'd0;
    for (int l = 0; l < 4; l++) if (exp_be[l]) m[8*l +: 8] = 8'hff;
    if (data_req_ex_i && !data_misaligned_ex_i) begin
      assert (data_misaligned_o == exp_mis) else report_error("data_misaligned_o wrong");
    end
    if (data_req_o && data_gnt_i && data_we_o) begin
      assert (data_be_o == exp_be) else report_error("store byte enables wrong");
      assert ((data_wdata_o & m) == (exp_lanes & m)) else report_error("store lanes wrong");
    end
    if (data_rvalid_i) begin
      resp_seen  = resp_seen + 1;
      last_rdata = data_rdata_ex_o;
    end
  endtask

  task automatic do_access();
    int t, mode, off, idx, n, addr, start, nph, ro;
    logic we, fill;
    logic [31:0] wd, wdr, opa, opb, expv;
    logic [7:0] mask8;
    we   = rand_below(2) == 1;
    t    = rand_below(4);                  // code 3 acts as a byte
    mode = rand_below(4);                  // code 3 acts as sign
    off  = rand_below(4);
    idx  = rand_below(63);                 // leaves room for the next word
    ro   = rand_below(4);                  // lane of the data inside the register
    wd   = 32'($random(seed));
    opb  = 32'(rand_below(256));
    for (int j = 0; j < 4; j++) begin
      wdr[8*j +: 8] = wd[8*((j + ro) % 4) +: 8];   // access byte j from register lane j+ro
    end
    n    = (t == 0) ? 4 : (t == 1) ? 2 : 1;
    addr = idx * 4 + off;
    mask8 = 8'(((1 << n) - 1) << off);
    nph  = (off + n > 4) ? 2 : 1;
    opa  = (rand_below(2) == 1) ? 32'(addr) - opb : 32'(addr);
    exp_mis   = (nph == 2);
    exp_be    = mask8[3:0];
    exp_lanes = lanes_for(wdr, off, n, 1'b0);
    start = resp_seen;
    data_req_ex_i        <= 1'b1;
    data_we_ex_i         <= we;
    data_type_ex_i       <= 2'(t);
    data_sign_ext_ex_i   <= 2'(mode);
    data_wdata_ex_i      <= wd;
    data_reg_offset_ex_i <= 2'(ro);
    operand_a_ex_i       <= opa;
    operand_b_ex_i       <= opb;
    addr_useincr_ex_i    <= (opa != 32'(addr));
    data_misaligned_ex_i <= 1'b0;
    do tick(); while (!lsu_ready_ex_o);
    if (nph == 2) begin                    // second phase in the next word
      exp_be    = mask8[7:4];
      exp_lanes = lanes_for(wdr, off, n, 1'b1);
      operand_a_ex_i       <= opa + 32'd4;
      data_misaligned_ex_i <= 1'b1;
      do tick(); while (!lsu_ready_ex_o);
    end
    data_req_ex_i <= 1'b0;                 // phase flag held until the last response
    while (resp_seen < start + nph) tick();
    data_misaligned_ex_i <= 1'b0;
    if (we) begin
      for (int k = 0; k < n; k++) shadow[addr + k] = wdr[8*k +: 8];
      for (int w = idx; w <= idx + 1; w++) begin
        assert (mem0.mem[w] == {shadow[4*w+3], shadow[4*w+2], shadow[4*w+1], shadow[4*w]})
          else report_error("memory differs from shadow after store");
      end
    end else begin
      expv = 32'd0;
      for (int k = 0; k < n; k++) expv[8*k +: 8] = shadow[addr + k];
      fill = (mode == 0) ? 1'b0 : (mode == 2) ? 1'b1 : expv[8*n-1];
      for (int b = 8 * n; b < 32; b++) expv[b] = fill;
      assert (last_rdata == expv) else report_error("load data wrong");
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    seed = 70726;
    cycles = 0;
    resp_seen = 0;
    last_rdata = 32'd0;
    exp_be = 4'd0;
    exp_lanes = 32'd0;
    exp_mis = 1'b0;
    data_req_ex_i = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = 2'd0;
    data_sign_ext_ex_i = 2'd0;
    data_wdata_ex_i = 32'd0;
    data_reg_offset_ex_i = 2'd0;
    operand_a_ex_i = 32'd0;
    operand_b_ex_i = 32'd0;
    addr_useincr_ex_i = 1'b0;
    data_misaligned_ex_i = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    tick();
    assert (!busy_o && !data_req_o && lsu_ready_wb_o && data_rdata_ex_o == 32'd0)
      else report_error("state after reset wrong");
    for (int i = 0; i < 64; i++) begin
      for (int b = 0; b < 4; b++) shadow[4*i + b] = mem0.mem[i][8*b +: 8];
    end
    for (int a = 0; a < NUM_ACCESS; a++) do_access();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
